//--- rtl/isaPkg.sv
package isaPkg;

	// machine-level widths
	typedef logic [31:0] word;
	typedef logic [4:0] regIdx;
	typedef logic [5:0] opcode;
	typedef logic [5:0] funct;
	typedef logic [15:0] imm16;

	// primary opcodes of the kept subset
	localparam opcode opRType = 6'h00;
	localparam opcode opAddi = 6'h08;
	localparam opcode opSlti = 6'h0a;
	localparam opcode opAndi = 6'h0c;
	localparam opcode opOri = 6'h0d;
	localparam opcode opXori = 6'h0e;
	localparam opcode opLw = 6'h23;
	localparam opcode opSw = 6'h2b;

	// function field of register-type words
	localparam funct fnAdd = 6'h20;
	localparam funct fnSub = 6'h22;
	localparam funct fnAnd = 6'h24;
	localparam funct fnOr = 6'h25;
	localparam funct fnXor = 6'h26;
	localparam funct fnNor = 6'h27;
	localparam funct fnSlt = 6'h2a;

	// internal ALU operation, decoded once in the decode stage
	typedef enum logic [2:0]
	{
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor,
		aluXor,
		aluSlt,
		aluNone // result forced to zero
	} aluOp;

endpackage

//--- rtl/pipePkg.sv
package pipePkg;

	// default memory sizes in words
	localparam int imemDepthDefault = 64;
	localparam int dmemDepthDefault = 64;

	typedef struct packed
	{
		logic valid;
		isaPkg::word instr;
	} ifIdReg;

	typedef struct packed
	{
		logic valid;
		isaPkg::aluOp aluOp;
		logic useImm; // operand B comes from imm
		logic memRead;
		logic memWrite;
		logic regWrite; // already cleared for r0
		isaPkg::regIdx dest;
		isaPkg::word opA;
		isaPkg::word opB;
		isaPkg::word imm; // extended immediate
	} idExReg;

	typedef struct packed
	{
		logic valid;
		logic memRead;
		logic memWrite;
		logic regWrite;
		isaPkg::regIdx dest;
		isaPkg::word aluResult; // also the data address
		isaPkg::word storeData;
	} exMemReg;

	// register file write port, also seen at the top level
	typedef struct packed
	{
		logic valid;
		isaPkg::regIdx idx;
		isaPkg::word data;
	} wbBus;

endpackage

//--- rtl/fetchStage.sv
module fetchStage #(
	parameter int imemDepth = pipePkg::imemDepthDefault
) (
	input logic clk,
	input logic rstN,
	input logic imemWrite,
	input isaPkg::word imemData,
	input logic run,
	input logic stall,
	output pipePkg::ifIdReg ifId
);
	localparam int ptrW = $clog2(imemDepth) + 1; // spare top bit marks the end

	isaPkg::word imem [imemDepth];
	logic [ptrW-1:0] loadPtr;
	logic [ptrW-1:0] pc;
	logic pcAtEnd;
	logic loadFull;
	isaPkg::word fetchWord;

	assign pcAtEnd = pc >= ptrW'(imemDepth);
	assign loadFull = loadPtr >= ptrW'(imemDepth);
	// past the end of memory the fetch sees a no-op word
	assign fetchWord = pcAtEnd ? '0 : imem[pc[ptrW-2:0]];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			loadPtr <= '0;
			pc <= '0;
			ifId <= '0;
			for (int i = 0; i < imemDepth; i++)
				imem[i] <= '0;
		end
		else
		begin
			if (imemWrite && !loadFull)
			begin
				imem[loadPtr[ptrW-2:0]] <= imemData;
				loadPtr <= loadPtr + 1'b1;
			end
			if (!stall) // under stall pc and ifId hold
			begin
				if (run)
				begin
					ifId.valid <= 1'b1;
					ifId.instr <= fetchWord;
					if (!pcAtEnd)
						pc <= pc + 1'b1;
				end
				else
					ifId.valid <= 1'b0;
			end
		end
	end

	loadInRange: assert property (@(posedge clk) disable iff (!rstN)
		imemWrite |-> loadPtr < ptrW'(imemDepth));

endmodule

//--- rtl/decodeStage.sv
module decodeStage (
	input logic clk,
	input logic rstN,
	input pipePkg::ifIdReg ifId,
	input isaPkg::word readDataA,
	input isaPkg::word readDataB,
	input isaPkg::regIdx exDest,
	input logic exRegWrite,
	input isaPkg::regIdx memDest,
	input logic memRegWrite,
	output isaPkg::regIdx readIdxA,
	output isaPkg::regIdx readIdxB,
	output logic stall,
	output pipePkg::idExReg idEx
);
	isaPkg::opcode opc;
	isaPkg::funct fn;
	isaPkg::regIdx rs, rt, rd;
	isaPkg::imm16 immRaw;
	isaPkg::aluOp decOp;
	isaPkg::regIdx dest;
	isaPkg::word immExt;
	logic useImm, memRead, memWrite, writes, signExt, readsRt;
	logic rsBusy, rtBusy;

	assign opc = ifId.instr[31:26];
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign fn = ifId.instr[5:0];
	assign immRaw = ifId.instr[15:0];

	always_comb
	begin
		decOp = isaPkg::aluNone;
		useImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		writes = 1'b0;
		signExt = 1'b0;
		readsRt = 1'b0;
		dest = rt; // rt unless register-type
		case (opc)
			isaPkg::opRType:
			begin
				dest = rd;
				readsRt = 1'b1;
				writes = 1'b1;
				case (fn)
					isaPkg::fnAdd: decOp = isaPkg::aluAdd;
					isaPkg::fnSub: decOp = isaPkg::aluSub;
					isaPkg::fnAnd: decOp = isaPkg::aluAnd;
					isaPkg::fnOr: decOp = isaPkg::aluOr;
					isaPkg::fnNor: decOp = isaPkg::aluNor;
					isaPkg::fnXor: decOp = isaPkg::aluXor;
					isaPkg::fnSlt: decOp = isaPkg::aluSlt;
					default: writes = 1'b0; // unknown funct acts as a no-op
				endcase
			end
			isaPkg::opAddi:
			begin
				decOp = isaPkg::aluAdd;
				useImm = 1'b1;
				signExt = 1'b1;
				writes = 1'b1;
			end
			isaPkg::opSlti:
			begin
				decOp = isaPkg::aluSlt;
				useImm = 1'b1;
				signExt = 1'b1;
				writes = 1'b1;
			end
			isaPkg::opAndi:
			begin
				decOp = isaPkg::aluAnd;
				useImm = 1'b1;
				writes = 1'b1;
			end
			isaPkg::opOri:
			begin
				decOp = isaPkg::aluOr;
				useImm = 1'b1;
				writes = 1'b1;
			end
			isaPkg::opXori:
			begin
				decOp = isaPkg::aluXor;
				useImm = 1'b1;
				writes = 1'b1;
			end
			isaPkg::opLw:
			begin
				decOp = isaPkg::aluAdd;
				useImm = 1'b1;
				signExt = 1'b1;
				writes = 1'b1;
				memRead = 1'b1;
			end
			isaPkg::opSw:
			begin
				decOp = isaPkg::aluAdd;
				useImm = 1'b1;
				signExt = 1'b1;
				memWrite = 1'b1;
				readsRt = 1'b1; // store data
			end
			default: ;
		endcase
	end

	assign immExt = signExt ? {{16{immRaw[15]}}, immRaw} : {16'b0, immRaw};
	assign readIdxA = rs;
	assign readIdxB = rt;

	// a source is busy while an older instruction in execute or memory will write it
	assign rsBusy = rs != '0 && ((exRegWrite && exDest == rs) || (memRegWrite && memDest == rs));
	assign rtBusy = rt != '0 && ((exRegWrite && exDest == rt) || (memRegWrite && memDest == rt));
	assign stall = ifId.valid && (rsBusy || (readsRt && rtBusy));

	always_ff @(posedge clk)
	begin
		if (!rstN || stall || !ifId.valid)
			idEx <= '0; // bubble
		else
		begin
			idEx.valid <= 1'b1;
			idEx.aluOp <= decOp;
			idEx.useImm <= useImm;
			idEx.memRead <= memRead;
			idEx.memWrite <= memWrite;
			idEx.regWrite <= writes && dest != '0;
			idEx.dest <= dest;
			idEx.opA <= readDataA;
			idEx.opB <= readDataB;
			idEx.imm <= immExt;
		end
	end

	// an older writer leaves execute and memory within two cycles
	stallBounded: assert property (@(posedge clk) disable iff (!rstN)
		stall[*2] |=> !stall);

endmodule

//--- rtl/regFile.sv
module regFile (
	input logic clk,
	input logic rstN,
	input isaPkg::regIdx readIdxA,
	input isaPkg::regIdx readIdxB,
	input pipePkg::wbBus wb,
	output isaPkg::word readDataA,
	output isaPkg::word readDataB
);
	isaPkg::word regs [32];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.idx != '0)
			regs[wb.idx] <= wb.data;
	end

	// r0 reads zero, a same-cycle write is passed straight through
	assign readDataA = (readIdxA == '0) ? '0 :
		(wb.valid && wb.idx == readIdxA) ? wb.data : regs[readIdxA];
	assign readDataB = (readIdxB == '0) ? '0 :
		(wb.valid && wb.idx == readIdxB) ? wb.data : regs[readIdxB];

	// decode must never let a write to r0 reach writeback
	noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> wb.idx != '0);

endmodule

//--- rtl/executeStage.sv
module executeStage (
	input logic clk,
	input logic rstN,
	input pipePkg::idExReg idEx,
	output pipePkg::exMemReg exMem
);
	isaPkg::word opA;
	isaPkg::word opB;
	isaPkg::word result;

	assign opA = idEx.opA;
	assign opB = idEx.useImm ? idEx.imm : idEx.opB;

	always_comb
	begin
		case (idEx.aluOp)
			isaPkg::aluAdd: result = opA + opB; // also lw/sw address
			isaPkg::aluSub: result = opA - opB;
			isaPkg::aluAnd: result = opA & opB;
			isaPkg::aluOr: result = opA | opB;
			isaPkg::aluNor: result = ~(opA | opB);
			isaPkg::aluXor: result = opA ^ opB;
			isaPkg::aluSlt:
			begin
				// signed compare
				if ($signed(opA) < $signed(opB))
					result = isaPkg::word'(1);
				else
					result = '0;
			end
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			exMem <= '0;
		else
		begin
			exMem.valid <= idEx.valid;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.regWrite <= idEx.regWrite;
			exMem.dest <= idEx.dest;
			exMem.aluResult <= result;
			exMem.storeData <= idEx.opB; // rt value, not the immediate
		end
	end

endmodule

//--- rtl/memoryStage.sv
module memoryStage #(
	parameter int dmemDepth = pipePkg::dmemDepthDefault
) (
	input logic clk,
	input logic rstN,
	input pipePkg::exMemReg exMem,
	output pipePkg::wbBus wb
);
	localparam int addrW = $clog2(dmemDepth);

	isaPkg::word dmem [dmemDepth];
	logic [addrW-1:0] addr;
	isaPkg::word loadWord;

	// word address, wraps around the small memory
	assign addr = addrW'(exMem.aluResult % dmemDepth);
	assign loadWord = dmem[addr];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < dmemDepth; i++)
				dmem[i] <= '0;
		end
		else if (exMem.valid && exMem.memWrite)
			dmem[addr] <= exMem.storeData;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			wb <= '0;
		else
		begin
			wb.valid <= exMem.valid && exMem.regWrite;
			wb.idx <= exMem.dest;
			wb.data <= exMem.memRead ? loadWord : exMem.aluResult;
		end
	end

	loadOrStore: assert property (@(posedge clk) disable iff (!rstN)
		!(exMem.memRead && exMem.memWrite));

endmodule

//--- rtl/pipeCpu.sv
module pipeCpu #(
	parameter int imemDepth = pipePkg::imemDepthDefault,
	parameter int dmemDepth = pipePkg::dmemDepthDefault
) (
	input logic clk,
	input logic rstN,
	input logic imemWrite,
	input isaPkg::word imemData,
	input logic run,
	output pipePkg::wbBus wb
);
	pipePkg::ifIdReg ifId;
	pipePkg::idExReg idEx;
	pipePkg::exMemReg exMem;
	logic stall;
	isaPkg::regIdx readIdxA;
	isaPkg::regIdx readIdxB;
	isaPkg::word readDataA;
	isaPkg::word readDataB;

	fetchStage #(.imemDepth(imemDepth)) fetch (
		.clk(clk),
		.rstN(rstN),
		.imemWrite(imemWrite),
		.imemData(imemData),
		.run(run),
		.stall(stall),
		.ifId(ifId)
	);

	// hazard inputs come from the execute and memory pipeline registers
	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.ifId(ifId),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.exDest(idEx.dest),
		.exRegWrite(idEx.regWrite),
		.memDest(exMem.dest),
		.memRegWrite(exMem.regWrite),
		.readIdxA(readIdxA),
		.readIdxB(readIdxB),
		.stall(stall),
		.idEx(idEx)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.readIdxA(readIdxA),
		.readIdxB(readIdxB),
		.wb(wb),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.exMem(exMem)
	);

	memoryStage #(.dmemDepth(dmemDepth)) memory (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem),
		.wb(wb)
	);

endmodule

//--- bench/pipeCpuTb.sv
module pipeCpuTb;
	localparam int progLen = 48;
	localparam int resetCycles = 10;
	localparam int driveDelay = 10;
	localparam int dmemWords = pipePkg::dmemDepthDefault;
	// load, three cycles per instruction at worst, then drain
	localparam int watchdogCycles = progLen + progLen * 3 + 20;

	logic clk;
	logic rstN;
	logic imemWrite;
	isaPkg::word imemData;
	logic run;
	pipePkg::wbBus wb;

	isaPkg::word prog [progLen];
	isaPkg::regIdx expIdx [$];
	isaPkg::word expData [$];
	logic [15:0] lfsrState;
	int expPos;
	int valueErrors;
	int protocolErrors;
	int timeoutErrors;

	pipeCpu #(
		.imemDepth(pipePkg::imemDepthDefault),
		.dmemDepth(pipePkg::dmemDepthDefault)
	) dut (
		.clk(clk),
		.rstN(rstN),
		.imemWrite(imemWrite),
		.imemData(imemData),
		.run(run),
		.wb(wb)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// 16-bit Galois LFSR
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int unsigned randBits(input int n);
		int unsigned val;
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			val = (val << 1) | lfsrState[0]; // one step per bit
			lfsrState = lfsrNext(lfsrState);
		end
		return val;
	endfunction

	function automatic isaPkg::word makeInstr(input int pos);
		isaPkg::regIdx rs;
		isaPkg::regIdx rt;
		isaPkg::regIdx rd;
		isaPkg::imm16 imm;
		isaPkg::funct fn;
		isaPkg::opcode op;
		int kind;
		rs = isaPkg::regIdx'(randBits(3)); // r0..r7 keeps hazards frequent
		rt = isaPkg::regIdx'(randBits(3));
		rd = isaPkg::regIdx'(randBits(3));
		imm = isaPkg::imm16'(randBits(16));
		kind = (pos < 8) ? 7 : int'(randBits(4) % 14);
		fn = isaPkg::fnAdd;
		op = isaPkg::opRType;
		case (kind)
			1: fn = isaPkg::fnSub;
			2: fn = isaPkg::fnAnd;
			3: fn = isaPkg::fnOr;
			4: fn = isaPkg::fnNor;
			5: fn = isaPkg::fnXor;
			6: fn = isaPkg::fnSlt;
			7: op = isaPkg::opAddi;
			8: op = isaPkg::opSlti;
			9: op = isaPkg::opAndi;
			10: op = isaPkg::opOri;
			11: op = isaPkg::opXori;
			12: op = isaPkg::opLw;
			13: op = isaPkg::opSw;
			default: ;
		endcase
		if (kind < 7)
			return {op, rs, rt, rd, 5'b0, fn};
		if (kind >= 12)
			return {op, 5'd0, rt, 12'b0, imm[3:0]}; // base r0 and offset 0..15
		return {op, rs, rt, imm};
	endfunction

	// ISA model stepping through the program in order
	function automatic void runModel();
		isaPkg::word regs [32];
		isaPkg::word mem [dmemWords];
		isaPkg::word a;
		isaPkg::word b;
		isaPkg::word sImm;
		isaPkg::word zImm;
		isaPkg::word res;
		isaPkg::regIdx dest;
		logic writes;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		for (int m = 0; m < dmemWords; m++)
			mem[m] = '0;
		for (int i = 0; i < progLen; i++)
		begin
			a = regs[prog[i][25:21]];
			b = regs[prog[i][20:16]];
			sImm = {{16{prog[i][15]}}, prog[i][15:0]};
			zImm = {16'b0, prog[i][15:0]};
			dest = prog[i][20:16];
			res = '0;
			writes = 1'b1;
			case (prog[i][31:26])
				isaPkg::opRType:
				begin
					dest = prog[i][15:11];
					case (prog[i][5:0])
						isaPkg::fnAdd: res = a + b;
						isaPkg::fnSub: res = a - b;
						isaPkg::fnAnd: res = a & b;
						isaPkg::fnOr: res = a | b;
						isaPkg::fnNor: res = ~(a | b);
						isaPkg::fnXor: res = a ^ b;
						isaPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				isaPkg::opAddi: res = a + sImm;
				isaPkg::opSlti: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
				isaPkg::opAndi: res = a & zImm;
				isaPkg::opOri: res = a | zImm;
				isaPkg::opXori: res = a ^ zImm;
				isaPkg::opLw: res = mem[(a + sImm) % dmemWords];
				isaPkg::opSw:
				begin
					mem[(a + sImm) % dmemWords] = b;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != '0)
			begin
				regs[dest] = res;
				expIdx.push_back(dest);
				expData.push_back(res);
			end
		end
	endfunction

	task automatic reportAndFinish();
		$display("errors: %0d value, %0d protocol, %0d timeout",
			valueErrors, protocolErrors, timeoutErrors);
		if (valueErrors + protocolErrors + timeoutErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	initial
	begin
		rstN = 1'b0;
		imemWrite = 1'b0;
		imemData = '0;
		run = 1'b0;
		expPos = 0;
		valueErrors = 0;
		protocolErrors = 0;
		timeoutErrors = 0;
		lfsrState = 16'd66;
		for (int i = 0; i < progLen; i++)
			prog[i] = makeInstr(i);
		runModel();
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;
		for (int i = 0; i < progLen; i++)
		begin
			@(posedge clk);
			#driveDelay;
			imemWrite = 1'b1;
			imemData = prog[i];
		end
		@(posedge clk);
		#driveDelay;
		imemWrite = 1'b0;
		imemData = '0;
		@(posedge clk);
		#driveDelay;
		run = 1'b1;
		wait (expPos == expIdx.size());
		repeat (8) @(posedge clk); // stray writes would show up here
		reportAndFinish();
	end

	// wb is registered on the rising edge, so look at it on the falling one
	always @(negedge clk)
	begin
		if (wb.valid === 1'b1)
		begin
			if (!run)
			begin
				protocolErrors++;
				$display("writeback seen at %0t before run was raised", $time);
			end
			else if (wb.idx == '0)
			begin
				protocolErrors++;
				$display("writeback to register 0 seen at %0t", $time);
			end
			else if (expPos >= expIdx.size())
			begin
				protocolErrors++;
				$display("more writebacks than expected, extra one at %0t", $time);
			end
			else
			begin
				if (wb.idx !== expIdx[expPos] || wb.data !== expData[expPos])
				begin
					valueErrors++;
					$display("** Error at %0t: write %0d expected r%0d = %h, got r%0d = %h",
						$time, expPos, expIdx[expPos], expData[expPos], wb.idx, wb.data);
				end
				expPos++;
			end
		end
	end

	initial
	begin
		wait (rstN === 1'b1);
		repeat (watchdogCycles) @(posedge clk);
		timeoutErrors++;
		$display("watchdog expired after %0d cycles, %0d of %0d register writes never arrived",
			watchdogCycles, expIdx.size() - expPos, expIdx.size());
		reportAndFinish();
	end

endmodule

//--- pipeCpu.f
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipeCpu.sv
bench/pipeCpuTb.sv
